/* Bender.yml */
package:
  name: rec

sources:
  - hw/rec_pkg.sv
  - hw/iqit_rescale.sv
  - hw/iqit_transform.sv
  - hw/rec_sum_pe.sv
  - hw/rec_mb_buffer.sv
  - hw/rec_top.sv
  - target: simulation
    files:
      - bench/rec_assert.sv
      - bench/rec_tb.sv

/* bench/rec_assert.sv */
//--------------------
// timing assertions on the reconstruction top
//--------------------
`timescale 1ns/1ps
`default_nettype none

module rec_assert import rec_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     blk_valid,
	input logic     blk_done,
	input logic     mb_done,
	input blk_idx_t done_idx
);

	// done follows the strobe cycle by five cycles
	property done_latency;
		@(posedge clk) disable iff (!rst_n) blk_done |-> $past(blk_valid, 5);
	endproperty

	assert property (done_latency)
		else $error("blk_done without a request five cycles before");

	assert property (@(posedge clk) mb_done |-> blk_done && done_idx == 4'd15)
		else $error("mb_done without blk_done on block 15");

	// sync reset, so pulses are clear one edge after rst_n is seen low
	assert property (@(posedge clk) $past(!rst_n) |-> !blk_done && !mb_done)
		else $error("done pulse while in reset");

endmodule

bind rec_top rec_assert rec_assert_i (.*);

`default_nettype wire

/* bench/rec_tb.sv */
//--------------------
// testbench for the luma reconstruction top
// reference model, directed tests, check task, summary
//--------------------
`timescale 1ns/1ps
`default_nettype none

module rec_tb import rec_pkg::*; ();

	typedef int quad_t [4];

	logic     clk;
	logic     rst_n;
	logic     blk_valid;
	rec_in_t  blk_in;
	logic     rd_en;
	rd_addr_t rd_addr;
	logic     blk_done;
	blk_idx_t done_idx;
	logic     mb_done;
	pix_row_t rd_data;

	int seed;
	int checks;
	int errors;

	rec_top rec_top_i (.*);

	always #2 clk = ~clk;

	//--------------------
	// reference model
	//--------------------
	function automatic pixel_t clip8(input int v);
		return (v < 0) ? 8'd0 : (v > 255) ? 8'd255 : pixel_t'(v);
	endfunction

	function automatic quad_t inv4(input quad_t a);
		int e;
		int f;
		int g;
		int h;
		quad_t y;
		e = a[0] + a[2];
		f = a[0] - a[2];
		g = (a[1] >>> 1) - a[3];
		h = a[1] + (a[3] >>> 1);
		y = '{e + h, f + g, f - g, e - h};
		return y;
	endfunction

	function automatic pred_blk_t model_block(input rec_in_t req);
		int w [16];
		int scale;
		quad_t q;
		quad_t y;
		pred_blk_t px;
		for (int i = 0; i < 16; i++) begin
			if ((i / 4) % 2 == 0 && (i % 4) % 2 == 0) begin
				scale = LEVEL_SCALE_EVEN[req.qp % 6];
			end else if ((i / 4) % 2 == 1 && (i % 4) % 2 == 1) begin
				scale = LEVEL_SCALE_ODD[req.qp % 6];
			end else begin
				scale = LEVEL_SCALE_MIXED[req.qp % 6];
			end
			w[i] = (int'($signed(req.coeffs[i])) * scale) <<< (req.qp / 6);
		end
		for (int r = 0; r < 4; r++) begin
			for (int k = 0; k < 4; k++) q[k] = w[r*4 + k];
			y = inv4(q);
			for (int k = 0; k < 4; k++) w[r*4 + k] = y[k];
		end
		// columns, then rounding and the sum with prediction
		for (int c = 0; c < 4; c++) begin
			for (int k = 0; k < 4; k++) q[k] = w[k*4 + c];
			y = inv4(q);
			for (int k = 0; k < 4; k++) begin
				px[k*4 + c] = clip8(((y[k] + 32) >>> 6) + int'(req.pred[k*4 + c]));
			end
		end
		return px;
	endfunction

	//--------------------
	// check and bus tasks
	//--------------------
	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic read_row(input blk_idx_t b, input logic [1:0] row, output pix_row_t data);
		@(posedge clk);
		rd_en <= 1'b1;
		rd_addr.blk_idx <= b;
		rd_addr.row <= row;
		@(posedge clk);
		rd_en <= 1'b0;
		@(negedge clk);
		data = rd_data;
	endtask

	task automatic check_block(input blk_idx_t b, input pred_blk_t expected);
		pix_row_t got;
		for (int r = 0; r < 4; r++) begin
			read_row(b, 2'(r), got);
			compare("rd_data", expected[r*4 +: 4], got);
		end
	endtask

	// one request, wait for its done pulse, read it back
	task automatic run_block(input rec_in_t req, input pred_blk_t expected);
		int n;
		@(posedge clk);
		blk_valid <= 1'b1;
		blk_in <= req;
		@(posedge clk);
		blk_valid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!blk_done && n < 20);
		if (!blk_done) begin
			errors++;
			$display("blk_done never came for block %0d", req.blk_idx);
		end else begin
			compare("blk_done latency", 5, n);
			compare("done_idx", req.blk_idx, done_idx);
			compare("mb_done", req.blk_idx == 15, mb_done);
			check_block(req.blk_idx, expected);
		end
	endtask

	//--------------------
	// directed tests
	//--------------------
	task automatic zero_residual();
		rec_in_t req;
		int e0;
		e0 = errors;
		for (int t = 0; t < 2; t++) begin
			req = '0;
			req.qp = qp_t'(t * 51);
			req.blk_idx = blk_idx_t'(2 + t);
			for (int i = 0; i < 16; i++) req.pred[i] = pixel_t'($random(seed));
			run_block(req, req.pred);
		end
		$display("zero residual finished, %0d errors", errors - e0);
	endtask

	task automatic dc_only();
		int dc_vals [3] = '{7, -13, 90};
		int qps [4] = '{0, 12, 28, 40};
		rec_in_t req;
		pred_blk_t expected;
		int res;
		int e0;
		e0 = errors;
		foreach (qps[q]) begin
			foreach (dc_vals[d]) begin
				req = '0;
				req.qp = qp_t'(qps[q]);
				req.blk_idx = blk_idx_t'(q * 3 + d);
				req.coeffs[0] = coeff_t'(dc_vals[d]);
				res = dc_vals[d] * int'(LEVEL_SCALE_EVEN[qps[q] % 6]);
				res = ((res <<< (qps[q] / 6)) + 32) >>> 6;
				for (int i = 0; i < 16; i++) begin
					req.pred[i] = pixel_t'(64 + $unsigned($random(seed)) % 128);
					expected[i] = clip8(int'(req.pred[i]) + res);
				end
				run_block(req, expected);
			end
		end
		$display("dc only finished, %0d errors", errors - e0);
	endtask

	task automatic clip_limits();
		rec_in_t req;
		int e0;
		e0 = errors;
		req = '0;
		req.qp = qp_t'(30);
		req.blk_idx = 4'd7;
		req.coeffs[0] = coeff_t'(200);
		req.pred = {16{8'd250}};
		run_block(req, {16{8'd255}});
		req.coeffs[0] = coeff_t'(-200);
		req.pred = {16{8'd5}};
		run_block(req, '0);
		$display("clipping finished, %0d errors", errors - e0);
	endtask

	task automatic full_macroblock();
		rec_in_t req [16];
		pred_blk_t expect_mb [16];
		int n;
		int dones;
		int mb_seen;
		int e0;
		e0 = errors;
		for (int b = 0; b < 16; b++) begin
			req[b] = '0;
			req[b].qp = qp_t'($unsigned($random(seed)) % 52);
			req[b].blk_idx = blk_idx_t'(b);
			for (int i = 0; i < 16; i++) begin
				req[b].coeffs[i] = coeff_t'($random(seed) % 64);
				req[b].pred[i] = pixel_t'($random(seed));
			end
			expect_mb[b] = model_block(req[b]);
		end
		n = 0;
		dones = 0;
		mb_seen = 0;
		@(negedge clk);
		fork
			begin
				for (int b = 0; b < 16; b++) begin
					@(posedge clk);
					blk_valid <= 1'b1;
					blk_in <= req[b];
				end
				@(posedge clk);
				blk_valid <= 1'b0;
			end
			while (dones < 16 && n < 40) begin
				@(negedge clk);
				n++;
				if (mb_done) begin
					mb_seen++;
					compare("done_idx at mb_done", 15, done_idx);
				end
				// block k strobed in cycle k, its done seen at negedge k + 6
				if (blk_done) begin
					compare("done_idx", dones, done_idx);
					compare("blk_done latency", 5, n - 1 - dones);
					dones++;
				end
			end
		join
		if (dones < 16) begin
			errors++;
			$display("only %0d of 16 blk_done pulses arrived", dones);
		end
		compare("mb_done count", 1, mb_seen);
		for (int b = 0; b < 16; b++) check_block(blk_idx_t'(b), expect_mb[b]);
		$display("full macroblock finished, %0d errors", errors - e0);
	endtask

	task automatic qp_sweep();
		int qps [5] = '{0, 5, 6, 29, 51};
		rec_in_t req;
		int e0;
		e0 = errors;
		foreach (qps[q]) begin
			req = '0;
			req.qp = qp_t'(qps[q]);
			req.blk_idx = blk_idx_t'(qps[q]);
			for (int i = 0; i < 16; i++) begin
				req.coeffs[i] = coeff_t'($random(seed) % 32);
				req.pred[i] = pixel_t'($random(seed));
			end
			run_block(req, model_block(req));
		end
		$display("qp sweep finished, %0d errors", errors - e0);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		blk_valid = 1'b0;
		blk_in = '0;
		rd_en = 1'b0;
		rd_addr = '0;
		seed = 32'h38f7;
		checks = 0;
		errors = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		zero_residual();
		dc_only();
		clip_limits();
		full_macroblock();
		qp_sweep();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hw/rec_pkg.sv
hw/iqit_rescale.sv
hw/iqit_transform.sv
hw/rec_sum_pe.sv
hw/rec_mb_buffer.sv
hw/rec_top.sv
bench/rec_assert.sv
bench/rec_tb.sv

/* hw/iqit_rescale.sv */
//--------------------
// qp based dequantization of one 4x4 coefficient block
//--------------------
`timescale 1ns/1ps
`default_nettype none

module iqit_rescale import rec_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    blk_valid,
	input  rec_in_t blk_in,
	output stage_t  rescaled,
	output logic    rescaled_valid
);

	logic [2:0] qp_rem;
	logic [3:0] qp_div;
	wide_blk_t  scaled;

	// table picked by row and column parity of the position
	function automatic wide_t level_scale(input logic [3:0] pos, input logic [2:0] rem);
		scale_t scale;
		if (!pos[2] && !pos[0]) begin
			scale = LEVEL_SCALE_EVEN[rem];
		end else if (pos[2] && pos[0]) begin
			scale = LEVEL_SCALE_ODD[rem];
		end else begin
			scale = LEVEL_SCALE_MIXED[rem];
		end
		return wide_t'(scale);
	endfunction

	always_comb begin
		qp_rem = 3'(blk_in.qp % 6);
		qp_div = 4'(blk_in.qp / 6);
		for (int i = 0; i < 16; i++) begin
			scaled[i] = (wide_t'($signed(blk_in.coeffs[i])) * level_scale(4'(i), qp_rem))
				<<< qp_div;
		end
	end

	//--------------------
	// output register
	//--------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rescaled_valid <= 1'b0;
		end else begin
			rescaled_valid <= blk_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (blk_valid) begin
			rescaled.data <= scaled;
			rescaled.pred <= blk_in.pred;
			rescaled.blk_idx <= blk_in.blk_idx;
		end
	end

endmodule

`default_nettype wire

/* hw/iqit_transform.sv */
//--------------------
// two pass 4x4 inverse integer transform
// row pass, then column pass with rounding
//--------------------
`timescale 1ns/1ps
`default_nettype none

module iqit_transform import rec_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  stage_t              rescaled,
	input  logic                rescaled_valid,
	output res_row_t [3:0]      res_rows,
	output pix_row_t [3:0]      pred_rows,
	output logic                xf_valid,
	output blk_idx_t            xf_blk_idx
);

	stage_t          row_q;
	logic            row_valid;
	wide_blk_t       row_xf;
	res_row_t [3:0]  res_next;

	// 1D inverse transform butterfly
	function automatic res_row_t idct4(input res_row_t a);
		wide_t    e;
		wide_t    f;
		wide_t    g;
		wide_t    h;
		res_row_t y;
		e = $signed(a[0]) + $signed(a[2]);
		f = $signed(a[0]) - $signed(a[2]);
		g = ($signed(a[1]) >>> 1) - $signed(a[3]);
		h = $signed(a[1]) + ($signed(a[3]) >>> 1);
		y[0] = e + h;
		y[1] = f + g;
		y[2] = f - g;
		y[3] = e - h;
		return y;
	endfunction

	//--------------------
	// stage one, rows
	//--------------------
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			row_xf[r*4 +: 4] = idct4(rescaled.data[r*4 +: 4]);
		end
	end

	always_ff @(posedge clk) begin
		if (rescaled_valid) begin
			row_q.data <= row_xf;
			row_q.pred <= rescaled.pred;
			row_q.blk_idx <= rescaled.blk_idx;
		end
	end

	//--------------------
	// stage two, columns
	//--------------------
	always_comb begin : col_pass
		res_row_t col_in;
		res_row_t col_out;
		for (int c = 0; c < 4; c++) begin
			for (int k = 0; k < 4; k++) begin
				col_in[k] = row_q.data[k*4 + c];
			end
			col_out = idct4(col_in);
			// round to nearest, back to residual scale
			for (int k = 0; k < 4; k++) begin
				res_next[k][c] = ($signed(col_out[k]) + wide_t'(32)) >>> 6;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid) begin
			res_rows <= res_next;
			xf_blk_idx <= row_q.blk_idx;
			for (int r = 0; r < 4; r++) begin
				pred_rows[r] <= row_q.pred[r*4 +: 4];
			end
		end
	end

	// valid pipe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			row_valid <= 1'b0;
			xf_valid <= 1'b0;
		end else begin
			row_valid <= rescaled_valid;
			xf_valid <= row_valid;
		end
	end

endmodule

`default_nettype wire

/* hw/rec_mb_buffer.sv */
//--------------------
// macroblock reconstruction buffer
// four row banks of 16 words, done pulses, registered read
//--------------------
`timescale 1ns/1ps
`default_nettype none

module rec_mb_buffer import rec_pkg::*; (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           xf_valid,
	input  blk_idx_t       xf_blk_idx,
	input  pix_row_t [3:0] rec_rows,
	input  logic           rd_en,
	input  rd_addr_t       rd_addr,
	output logic           blk_done,
	output blk_idx_t       done_idx,
	output logic           mb_done,
	output pix_row_t       rd_data
);

	logic     wr_valid;
	blk_idx_t wr_idx;
	pix_row_t bank [ROWS_PER_BLK][BLK_PER_MB];

	//--------------------
	// align valid with the sum pe outputs
	//--------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_valid <= 1'b0;
		end else begin
			wr_valid <= xf_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (xf_valid) begin
			wr_idx <= xf_blk_idx;
		end
	end

	// whole block in one cycle, one row per bank
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			for (int r = 0; r < ROWS_PER_BLK; r++) begin
				bank[r][wr_idx] <= rec_rows[r];
			end
		end
	end

	//--------------------
	// done pulses
	//--------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			blk_done <= 1'b0;
			mb_done <= 1'b0;
		end else begin
			blk_done <= wr_valid;
			mb_done <= wr_valid && (wr_idx == blk_idx_t'(BLK_PER_MB - 1));
		end
	end

	always_ff @(posedge clk) begin
		if (wr_valid) begin
			done_idx <= wr_idx;
		end
	end

	// read port, old data on a same cycle write
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= bank[rd_addr.row][rd_addr.blk_idx];
		end
	end

endmodule

`default_nettype wire

/* hw/rec_pkg.sv */
//--------------------
// shared types and constants of the luma reconstruction path
// pixel, coefficient, block and row types, level-scale tables
//--------------------
`default_nettype none

package rec_pkg;

	//--------------------
	// scalar types
	//--------------------
	typedef logic [7:0] pixel_t;
	typedef logic signed [8:0] coeff_t;
	typedef logic signed [25:0] wide_t;
	typedef logic [5:0] qp_t;
	typedef logic [3:0] blk_idx_t;
	typedef logic [4:0] scale_t;

	// blocks in raster order, index = row * 4 + column
	typedef coeff_t [15:0] coeff_blk_t;
	typedef pixel_t [15:0] pred_blk_t;
	typedef wide_t [15:0] wide_blk_t;

	// one row of a block, pix_row_t is also the buffer word
	typedef pixel_t [3:0] pix_row_t;
	typedef wide_t [3:0] res_row_t;

	typedef struct packed {
		coeff_blk_t coeffs;
		pred_blk_t  pred;
		qp_t        qp;
		blk_idx_t   blk_idx;
	} rec_in_t;

	typedef struct packed {
		wide_blk_t data;
		pred_blk_t pred;
		blk_idx_t  blk_idx;
	} stage_t;

	typedef struct packed {
		blk_idx_t   blk_idx;
		logic [1:0] row;
	} rd_addr_t;

	//--------------------
	// constants
	//--------------------
	localparam int BLK_PER_MB = 16;
	localparam int ROWS_PER_BLK = 4;

	// indexed by qp mod 6
	localparam scale_t LEVEL_SCALE_EVEN [6] = '{5'd10, 5'd11, 5'd13, 5'd14, 5'd16, 5'd18};
	localparam scale_t LEVEL_SCALE_ODD [6] = '{5'd16, 5'd18, 5'd20, 5'd23, 5'd25, 5'd29};
	localparam scale_t LEVEL_SCALE_MIXED [6] = '{5'd13, 5'd14, 5'd16, 5'd18, 5'd20, 5'd23};

endpackage

`default_nettype wire

/* hw/rec_sum_pe.sv */
//--------------------
// residual plus prediction for one row, clipped to 8 bits
//--------------------
`timescale 1ns/1ps
`default_nettype none

module rec_sum_pe import rec_pkg::*; (
	input  logic     clk,
	input  res_row_t res_row,
	input  pix_row_t pred_row,
	output pix_row_t rec_row
);

	pix_row_t clipped;

	function automatic pixel_t clip_pixel(input wide_t v);
		if (v < 0) begin
			return 8'd0;
		end else if (v > 255) begin
			return 8'd255;
		end else begin
			return v[7:0];
		end
	endfunction

	// four adders in parallel
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			clipped[i] = clip_pixel($signed(res_row[i]) + wide_t'(pred_row[i]));
		end
	end

	always_ff @(posedge clk) begin
		rec_row <= clipped;
	end

endmodule

`default_nettype wire

/* hw/rec_top.sv */
//--------------------
// luma residual reconstruction top
// rescale, inverse transform, four sum pes, mb buffer
//--------------------
`timescale 1ns/1ps
`default_nettype none

module rec_top import rec_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     blk_valid,
	input  rec_in_t  blk_in,
	input  logic     rd_en,
	input  rd_addr_t rd_addr,
	output logic     blk_done,
	output blk_idx_t done_idx,
	output logic     mb_done,
	output pix_row_t rd_data
);

	stage_t         rescaled;
	logic           rescaled_valid;
	res_row_t [3:0] res_rows;
	pix_row_t [3:0] pred_rows;
	logic           xf_valid;
	blk_idx_t       xf_blk_idx;
	pix_row_t [3:0] rec_row;

	iqit_rescale iqit_rescale_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.blk_valid      (blk_valid),
		.blk_in         (blk_in),
		.rescaled       (rescaled),
		.rescaled_valid (rescaled_valid)
	);

	iqit_transform iqit_transform_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.rescaled       (rescaled),
		.rescaled_valid (rescaled_valid),
		.res_rows       (res_rows),
		.pred_rows      (pred_rows),
		.xf_valid       (xf_valid),
		.xf_blk_idx     (xf_blk_idx)
	);

	// one sum pe per block row
	for (genvar i = 0; i < ROWS_PER_BLK; i++) begin : g_sum_pe
		rec_sum_pe rec_sum_pe_i (
			.clk      (clk),
			.res_row  (res_rows[i]),
			.pred_row (pred_rows[i]),
			.rec_row  (rec_row[i])
		);
	end

	rec_mb_buffer rec_mb_buffer_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.xf_valid   (xf_valid),
		.xf_blk_idx (xf_blk_idx),
		.rec_rows   (rec_row),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.blk_done   (blk_done),
		.done_idx   (done_idx),
		.mb_done    (mb_done),
		.rd_data    (rd_data)
	);

endmodule

`default_nettype wire
